// ==== contour_tracer_top.f ====
hw/contour_pkg.sv
hw/label_ram.sv
hw/raster_counter.sv
hw/neighbor_addr.sv
hw/trace_fsm.sv
hw/contour_tracer_top.sv
sim/contour_tracer_tb.sv

// ==== Bender.yml ====
package:
  name: contour_tracer

sources:
  - hw/contour_pkg.sv
  - hw/label_ram.sv
  - hw/raster_counter.sv
  - hw/neighbor_addr.sv
  - hw/trace_fsm.sv
  - hw/contour_tracer_top.sv
  - target: simulation
    files:
      - sim/contour_tracer_tb.sv

// ==== sim/contour_golden.txt ====
# Per frame: test name and expected num_pixels, 8 input rows, 8 expected output rows
# Each row holds 12 labels of one digit each, leftmost column first
closed_loop 19
000000000000
003333333200
003000003000
003000003000
003000003000
003333333000
000000000000
500000000000
000000000000
001111111000
001000001000
001000001000
001000001000
001111111000
000000000000
000000000000
open_curve 6
330000000000
003400000000
003000000000
030000000000
300000000000
300000000000
000000000030
000000000000
110000000000
001000000000
001000000000
010000000000
100000000000
100000000000
000000000000
000000000000
empty_frame 0
000000000000
000000000000
000000000000
000120560000
000000000000
000000000000
000000000000
000000000000
000000000000
000000000000
000000000000
000000000000
000000000000
000000000000
000000000000
000000000000

// ==== sim/contour_tracer_tb.sv ====
module contour_tracer_tb;

    localparam int WIDTH       = 12;
    localparam int HEIGHT      = 8;
    localparam int NPIX        = WIDTH * HEIGHT;
    localparam int NUM_FRAMES  = 3;
    localparam int FRAME_LINES = 1 + 2 * HEIGHT;
    // Ten times every pixel of every frame, eight probes each
    localparam int CYCLE_LIMIT = 10 * NUM_FRAMES * NPIX * 8;
    localparam GOLDEN_FILE     = "sim/contour_golden.txt";

    logic                       clk;
    logic                       rst_n;
    logic                       start;
    logic                       in_valid;
    logic                       in_ready;
    contour_pkg::label_t        in_label;
    logic                       out_valid;
    logic                       out_ready;
    contour_pkg::label_t        out_label;
    logic                       done;
    logic [$clog2(NPIX)-1:0]    num_pixels;

    string                      names     [NUM_FRAMES];
    int                         exp_count [NUM_FRAMES];
    contour_pkg::label_t        in_px     [NUM_FRAMES * NPIX];
    contour_pkg::label_t        exp_px    [NUM_FRAMES * NPIX];
    int                         cycles = 0;

    contour_tracer_top #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_label   (in_label),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_label  (out_label),
        .done       (done),
        .num_pixels (num_pixels)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            fail_run($sformatf("CHECK FAILED %s: expected %0d, actual %0d",
                               what, expected, actual));
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            fail_run($sformatf("Run timed out after %0d cycles with the controller in %s",
                               cycles, i_dut.i_trace_fsm.state.name()));
        end
    end

    ////////////////////////////////////////
    // Golden file
    ////////////////////////////////////////

    task automatic read_golden();
        int    fd;
        int    k;
        int    f;
        int    part;
        int    row;
        int    sp;
        int    base;
        string line;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            fail_run("Could not open the golden file");
        end
        k = 0;
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
                if (k >= NUM_FRAMES * FRAME_LINES) begin
                    fail_run("Golden file holds more lines than the frames need");
                end
                f    = k / FRAME_LINES;
                part = k % FRAME_LINES;
                if (part == 0) begin
                    // Name then expected count
                    sp = 0;
                    while (sp < line.len() && line[sp] != " ") begin
                        sp++;
                    end
                    names[f]     = line.substr(0, sp - 1);
                    exp_count[f] = line.substr(sp + 1, line.len() - 1).atoi();
                end else begin
                    if (line.len() < WIDTH) begin
                        fail_run("Golden file has a row with fewer than twelve labels");
                    end
                    row  = (part - 1) % HEIGHT;
                    base = f * NPIX + row * WIDTH;
                    for (int i = 0; i < WIDTH; i++) begin
                        if (part <= HEIGHT) begin
                            in_px[base + i] = 3'(line[i] - 8'h30);
                        end else begin
                            exp_px[base + i] = 3'(line[i] - 8'h30);
                        end
                    end
                end
                k++;
            end
        end
        $fclose(fd);
        if (k != NUM_FRAMES * FRAME_LINES) begin
            fail_run("Golden file ended before all frames were read");
        end
    endtask

    ////////////////////////////////////////
    // Stimulus and response
    ////////////////////////////////////////

    task automatic start_frame();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // Random gaps in valid, held stable until accepted
    task automatic load_frame(input int f);
        int p;
        bit fire;
        p = 0;
        while (p < NPIX) begin
            @(posedge clk);
            fire = in_valid && in_ready;
            if (fire) begin
                p++;
            end
            if (p == NPIX) begin
                in_valid <= 1'b0;
            end else if (fire || !in_valid) begin
                if (($urandom % 4) != 0) begin
                    in_valid <= 1'b1;
                    in_label <= in_px[f * NPIX + p];
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
    endtask

    task automatic collect_frame(input int f);
        int beats;
        bit poked;
        beats = 0;
        poked = 1'b0;
        while (beats < NPIX) begin
            @(posedge clk);
            check_value($sformatf("%s done low at beat %0d", names[f], beats), 0, done);
            if (out_valid && out_ready) begin
                check_value($sformatf("%s pixel %0d", names[f], beats),
                            exp_px[f * NPIX + beats], out_label);
                beats++;
            end
            out_ready <= (beats < NPIX) && (($urandom % 3) != 0);
            // Stray start halfway through the output
            if (beats == NPIX / 2 && !poked) begin
                start <= 1'b1;
                poked = 1'b1;
            end else begin
                start <= 1'b0;
            end
        end
        @(posedge clk);
        check_value($sformatf("%s done after last beat", names[f]), 1, done);
        check_value($sformatf("%s out_valid after last beat", names[f]), 0, out_valid);
        @(posedge clk);
        check_value($sformatf("%s done one cycle only", names[f]), 0, done);
        check_value($sformatf("%s num_pixels", names[f]), exp_count[f], num_pixels);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        in_valid  = 1'b0;
        in_label  = contour_pkg::LABEL_NONE;
        out_ready = 1'b0;
        void'($urandom(32'h31a5bf40));
        read_golden();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("after reset in_ready", 0, in_ready);
        check_value("after reset out_valid", 0, out_valid);
        check_value("after reset done", 0, done);
        check_value("after reset num_pixels", 0, num_pixels);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            start_frame();
            load_frame(f);
            collect_frame(f);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== hw/contour_tracer_top.sv ====
module contour_tracer_top #(
    parameter int WIDTH  = 640,
    parameter int HEIGHT = 480,
    localparam int NPIX  = WIDTH * HEIGHT,
    localparam int AW    = (NPIX > 1) ? $clog2(NPIX) : 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                in_valid,
    output logic                in_ready,
    input  contour_pkg::label_t in_label,
    output logic                out_valid,
    input  logic                out_ready,
    output contour_pkg::label_t out_label,
    output logic                done,
    output logic [AW-1:0]       num_pixels
);

    localparam int XW = (WIDTH > 1) ? $clog2(WIDTH) : 1;
    localparam int YW = (HEIGHT > 1) ? $clog2(HEIGHT) : 1;

    // Memory port
    logic                wr_en;
    logic [AW-1:0]       wr_addr;
    contour_pkg::label_t wr_label;
    logic [AW-1:0]       rd_addr;
    contour_pkg::label_t rd_label;

    // Raster counter
    logic                cnt_clear;
    logic                cnt_step;
    logic [AW-1:0]       cnt_addr;
    logic [XW-1:0]       cnt_x;
    logic [YW-1:0]       cnt_y;
    logic                cnt_last;

    // Neighbour unit
    logic [AW-1:0]       cur_addr;
    logic [XW-1:0]       cur_x;
    logic [YW-1:0]       cur_y;
    logic [AW-1:0]       prev_addr;
    logic                has_prev;
    contour_pkg::dir_t   dir;
    logic [AW-1:0]       probe_addr;
    logic                probe_skip;

    label_ram #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) i_label_ram (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_label (wr_label),
        .rd_addr  (rd_addr),
        .rd_label (rd_label)
    );

    raster_counter #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) i_raster_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (cnt_clear),
        .step  (cnt_step),
        .addr  (cnt_addr),
        .x     (cnt_x),
        .y     (cnt_y),
        .last  (cnt_last)
    );

    neighbor_addr #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) i_neighbor_addr (
        .cur_addr   (cur_addr),
        .cur_x      (cur_x),
        .cur_y      (cur_y),
        .prev_addr  (prev_addr),
        .has_prev   (has_prev),
        .dir        (dir),
        .probe_addr (probe_addr),
        .probe_skip (probe_skip)
    );

    trace_fsm #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) i_trace_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_label   (in_label),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_label  (out_label),
        .done       (done),
        .num_pixels (num_pixels),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_label   (wr_label),
        .rd_addr    (rd_addr),
        .rd_label   (rd_label),
        .cnt_clear  (cnt_clear),
        .cnt_step   (cnt_step),
        .cnt_addr   (cnt_addr),
        .cnt_x      (cnt_x),
        .cnt_y      (cnt_y),
        .cnt_last   (cnt_last),
        .cur_addr   (cur_addr),
        .cur_x      (cur_x),
        .cur_y      (cur_y),
        .prev_addr  (prev_addr),
        .has_prev   (has_prev),
        .dir        (dir),
        .probe_addr (probe_addr),
        .probe_skip (probe_skip)
    );

endmodule

// ==== hw/trace_fsm.sv ====
module trace_fsm #(
    parameter int WIDTH  = 640,
    parameter int HEIGHT = 480,
    localparam int NPIX  = WIDTH * HEIGHT,
    localparam int AW    = (NPIX > 1) ? $clog2(NPIX) : 1,
    localparam int XW    = (WIDTH > 1) ? $clog2(WIDTH) : 1,
    localparam int YW    = (HEIGHT > 1) ? $clog2(HEIGHT) : 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                in_valid,
    output logic                in_ready,
    input  contour_pkg::label_t in_label,
    output logic                out_valid,
    input  logic                out_ready,
    output contour_pkg::label_t out_label,
    output logic                done,
    output logic [AW-1:0]       num_pixels,
    output logic                wr_en,
    output logic [AW-1:0]       wr_addr,
    output contour_pkg::label_t wr_label,
    output logic [AW-1:0]       rd_addr,
    input  contour_pkg::label_t rd_label,
    output logic                cnt_clear,
    output logic                cnt_step,
    input  logic [AW-1:0]       cnt_addr,
    input  logic [XW-1:0]       cnt_x,
    input  logic [YW-1:0]       cnt_y,
    input  logic                cnt_last,
    output logic [AW-1:0]       cur_addr,
    output logic [XW-1:0]       cur_x,
    output logic [YW-1:0]       cur_y,
    output logic [AW-1:0]       prev_addr,
    output logic                has_prev,
    output contour_pkg::dir_t   dir,
    input  logic [AW-1:0]       probe_addr,
    input  logic                probe_skip
);

    contour_pkg::state_t state;
    contour_pkg::state_t ret_state;
    logic                wait_second;
    logic                pend;
    logic [AW-1:0]       start_addr;

    logic                start_go;
    logic                load_beat;
    logic                out_beat;
    logic                find_hit;
    logic                find_miss_end;
    logic                loop_closed;
    logic                accept;
    logic                last_dir;
    logic                trace_end;
    logic                rd_issue;
    logic [AW-1:0]       rd_next;

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    assign last_dir  = (dir == contour_pkg::DIR_UP_RIGHT);
    assign start_go  = (state == contour_pkg::ST_IDLE) && start;
    assign in_ready  = (state == contour_pkg::ST_LOAD);
    assign load_beat = in_valid && in_ready;

    // pend marks a read whose data is on rd_label
    assign find_hit      = (state == contour_pkg::ST_FIND) && pend &&
                           (rd_label == contour_pkg::LABEL_EDGE);
    assign find_miss_end = (state == contour_pkg::ST_FIND) && pend &&
                           (rd_label != contour_pkg::LABEL_EDGE) && cnt_last;

    // Back at the start pixel from elsewhere closes the loop
    assign loop_closed = (state == contour_pkg::ST_PROBE) &&
                         (probe_addr == start_addr) && (cur_addr != start_addr);
    assign accept      = (state == contour_pkg::ST_PROBE) && !loop_closed &&
                         (rd_label == contour_pkg::LABEL_EDGE);
    assign trace_end   = ((state == contour_pkg::ST_EXPLORE) && probe_skip && last_dir) ||
                         loop_closed ||
                         ((state == contour_pkg::ST_PROBE) && !accept && last_dir);

    assign out_valid = (state == contour_pkg::ST_STREAM) && pend;
    assign out_label = (rd_label == contour_pkg::LABEL_TRACED) ?
                       contour_pkg::LABEL_CONTOUR : contour_pkg::LABEL_NONE;
    assign out_beat  = out_valid && out_ready;

    assign cnt_clear = start_go || find_miss_end || trace_end;

    always_comb begin
        wr_en    = 1'b0;
        wr_addr  = cnt_addr;
        wr_label = in_label;
        cnt_step = 1'b0;
        rd_issue = 1'b0;
        rd_next  = cnt_addr;
        case (state)
            contour_pkg::ST_LOAD: begin
                wr_en    = load_beat;
                cnt_step = load_beat;
            end
            contour_pkg::ST_FIND: begin
                rd_issue = !pend;
                if (find_hit) begin
                    wr_en    = 1'b1;
                    wr_label = contour_pkg::LABEL_TRACED;
                end else if (pend && !cnt_last) begin
                    cnt_step = 1'b1;
                end
            end
            contour_pkg::ST_EXPLORE: begin
                rd_issue = !probe_skip;
                rd_next  = probe_addr;
            end
            contour_pkg::ST_PROBE: begin
                if (accept) begin
                    wr_en    = 1'b1;
                    wr_addr  = probe_addr;
                    wr_label = contour_pkg::LABEL_TRACED;
                end
            end
            contour_pkg::ST_STREAM: begin
                rd_issue = !pend;
                cnt_step = out_beat;
            end
            default: begin
            end
        endcase
    end

    ////////////////////////////////////////
    // Control state
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= contour_pkg::ST_IDLE;
            ret_state   <= contour_pkg::ST_IDLE;
            wait_second <= 1'b0;
            pend        <= 1'b0;
            has_prev    <= 1'b0;
            dir         <= contour_pkg::DIR_RIGHT;
            num_pixels  <= '0;
            done        <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                contour_pkg::ST_IDLE: begin
                    if (start_go) begin
                        num_pixels <= '0;
                        state      <= contour_pkg::ST_LOAD;
                    end
                end
                contour_pkg::ST_LOAD: begin
                    if (load_beat && cnt_last) begin
                        state <= contour_pkg::ST_FIND;
                    end
                end
                contour_pkg::ST_FIND: begin
                    if (!pend) begin
                        pend      <= 1'b1;
                        ret_state <= contour_pkg::ST_FIND;
                        state     <= contour_pkg::ST_WAIT;
                    end else begin
                        pend <= 1'b0;
                        if (find_hit) begin
                            has_prev <= 1'b0;
                            dir      <= contour_pkg::DIR_RIGHT;
                            state    <= contour_pkg::ST_EXPLORE;
                        end else if (find_miss_end) begin
                            // Empty trace
                            state <= contour_pkg::ST_STREAM;
                        end
                    end
                end
                contour_pkg::ST_EXPLORE: begin
                    if (!probe_skip) begin
                        ret_state <= contour_pkg::ST_PROBE;
                        state     <= contour_pkg::ST_WAIT;
                    end else if (trace_end) begin
                        state <= contour_pkg::ST_STREAM;
                    end else begin
                        dir <= contour_pkg::dir_t'(dir + 3'd1);
                    end
                end
                contour_pkg::ST_PROBE: begin
                    if (trace_end) begin
                        state <= contour_pkg::ST_STREAM;
                    end else if (accept) begin
                        has_prev   <= 1'b1;
                        dir        <= contour_pkg::DIR_RIGHT;
                        num_pixels <= num_pixels + 1'b1;
                        state      <= contour_pkg::ST_EXPLORE;
                    end else begin
                        dir   <= contour_pkg::dir_t'(dir + 3'd1);
                        state <= contour_pkg::ST_EXPLORE;
                    end
                end
                contour_pkg::ST_STREAM: begin
                    if (!pend) begin
                        pend      <= 1'b1;
                        ret_state <= contour_pkg::ST_STREAM;
                        state     <= contour_pkg::ST_WAIT;
                    end else if (out_beat) begin
                        pend <= 1'b0;
                        if (cnt_last) begin
                            done  <= 1'b1;
                            state <= contour_pkg::ST_IDLE;
                        end
                    end
                end
                contour_pkg::ST_WAIT: begin
                    // Two cycles of read latency
                    wait_second <= !wait_second;
                    if (wait_second) begin
                        state <= ret_state;
                    end
                end
                default: begin
                    state <= contour_pkg::ST_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Addresses and pixel position
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rd_issue) begin
            rd_addr <= rd_next;
        end
        if (find_hit) begin
            start_addr <= cnt_addr;
            cur_addr   <= cnt_addr;
            cur_x      <= cnt_x;
            cur_y      <= cnt_y;
        end else if (accept) begin
            prev_addr <= cur_addr;
            cur_addr  <= probe_addr;
            cur_x     <= cur_x + XW'(contour_pkg::dir_dx(dir));
            cur_y     <= cur_y + YW'(contour_pkg::dir_dy(dir));
        end
    end

endmodule

// ==== hw/neighbor_addr.sv ====
module neighbor_addr #(
    parameter int WIDTH  = 640,
    parameter int HEIGHT = 480,
    localparam int NPIX  = WIDTH * HEIGHT,
    localparam int AW    = (NPIX > 1) ? $clog2(NPIX) : 1,
    localparam int XW    = (WIDTH > 1) ? $clog2(WIDTH) : 1,
    localparam int YW    = (HEIGHT > 1) ? $clog2(HEIGHT) : 1
) (
    input  logic              [AW-1:0] cur_addr,
    input  logic              [XW-1:0] cur_x,
    input  logic              [YW-1:0] cur_y,
    input  logic              [AW-1:0] prev_addr,
    input  logic                       has_prev,
    input  contour_pkg::dir_t          dir,
    output logic              [AW-1:0] probe_addr,
    output logic                       probe_skip
);

    localparam logic [AW-1:0] ROW = AW'(WIDTH);

    logic signed [1:0] dx;
    logic signed [1:0] dy;
    logic [AW-1:0]     col_off;
    logic [AW-1:0]     row_off;
    logic              outside;

    assign dx = contour_pkg::dir_dx(dir);
    assign dy = contour_pkg::dir_dy(dir);

    always_comb begin
        case (dx)
            2'sd1:   col_off = AW'(1);
            -2'sd1:  col_off = {AW{1'b1}};
            default: col_off = '0;
        endcase
        case (dy)
            2'sd1:   row_off = ROW;
            -2'sd1:  row_off = -ROW;
            default: row_off = '0;
        endcase
    end

    assign probe_addr = cur_addr + row_off + col_off;

    // Neighbours past any frame border are never probed
    assign outside = (dx == 2'sd1  && cur_x == XW'(WIDTH - 1))  ||
                     (dx == -2'sd1 && cur_x == '0)              ||
                     (dy == 2'sd1  && cur_y == YW'(HEIGHT - 1)) ||
                     (dy == -2'sd1 && cur_y == '0);

    assign probe_skip = outside || (has_prev && probe_addr == prev_addr);

endmodule

// ==== hw/raster_counter.sv ====
module raster_counter #(
    parameter int WIDTH  = 640,
    parameter int HEIGHT = 480,
    localparam int NPIX  = WIDTH * HEIGHT,
    localparam int AW    = (NPIX > 1) ? $clog2(NPIX) : 1,
    localparam int XW    = (WIDTH > 1) ? $clog2(WIDTH) : 1,
    localparam int YW    = (HEIGHT > 1) ? $clog2(HEIGHT) : 1
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          clear,
    input  logic          step,
    output logic [AW-1:0] addr,
    output logic [XW-1:0] x,
    output logic [YW-1:0] y,
    output logic          last
);

    assign last = (addr == AW'(NPIX - 1));

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            addr <= '0;
            x    <= '0;
            y    <= '0;
        end else if (step) begin
            if (last) begin
                // Wrap to the first pixel
                addr <= '0;
                x    <= '0;
                y    <= '0;
            end else if (x == XW'(WIDTH - 1)) begin
                addr <= addr + 1'b1;
                x    <= '0;
                y    <= y + 1'b1;
            end else begin
                addr <= addr + 1'b1;
                x    <= x + 1'b1;
            end
        end
    end

endmodule

// ==== hw/label_ram.sv ====
module label_ram #(
    parameter int WIDTH  = 640,
    parameter int HEIGHT = 480,
    localparam int NPIX  = WIDTH * HEIGHT,
    localparam int AW    = (NPIX > 1) ? $clog2(NPIX) : 1
) (
    input  logic                clk,
    input  logic                wr_en,
    input  logic [AW-1:0]       wr_addr,
    input  contour_pkg::label_t wr_label,
    input  logic [AW-1:0]       rd_addr,
    output contour_pkg::label_t rd_label
);

    contour_pkg::label_t mem [NPIX];
    logic [AW-1:0]       rd_addr_q;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_label;
        end
    end

    // Address register then data register, two cycles in total
    always_ff @(posedge clk) begin
        rd_addr_q <= rd_addr;
        rd_label  <= mem[rd_addr_q];
    end

endmodule

// ==== hw/contour_pkg.sv ====
package contour_pkg;

    ////////////////////////////////////////
    // Pixel labels
    ////////////////////////////////////////

    typedef logic [2:0] label_t;

    localparam label_t LABEL_NONE    = 3'b000;
    localparam label_t LABEL_CONTOUR = 3'b001;
    localparam label_t LABEL_EDGE    = 3'b011;
    localparam label_t LABEL_TRACED  = 3'b111;

    // Encoding order is the search priority
    typedef enum logic [2:0] {
        DIR_RIGHT      = 3'd0,
        DIR_DOWN_RIGHT = 3'd1,
        DIR_DOWN       = 3'd2,
        DIR_DOWN_LEFT  = 3'd3,
        DIR_LEFT       = 3'd4,
        DIR_UP_LEFT    = 3'd5,
        DIR_UP         = 3'd6,
        DIR_UP_RIGHT   = 3'd7
    } dir_t;

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_LOAD    = 3'd1,
        ST_FIND    = 3'd2,
        ST_EXPLORE = 3'd3,
        ST_PROBE   = 3'd4,
        ST_STREAM  = 3'd5,
        ST_WAIT    = 3'd6
    } state_t;

    // Column step of a direction
    function automatic logic signed [1:0] dir_dx(dir_t d);
        case (d)
            DIR_RIGHT, DIR_DOWN_RIGHT, DIR_UP_RIGHT: dir_dx = 2'sd1;
            DIR_DOWN_LEFT, DIR_LEFT, DIR_UP_LEFT:    dir_dx = -2'sd1;
            default:                                 dir_dx = 2'sd0;
        endcase
    endfunction

    // Row step of a direction
    function automatic logic signed [1:0] dir_dy(dir_t d);
        case (d)
            DIR_DOWN_RIGHT, DIR_DOWN, DIR_DOWN_LEFT: dir_dy = 2'sd1;
            DIR_UP_LEFT, DIR_UP, DIR_UP_RIGHT:       dir_dy = -2'sd1;
            default:                                 dir_dy = 2'sd0;
        endcase
    endfunction

endpackage
